// File: rtl/game_pkg.sv
// Shared types and constants of the video board
//   vid_t      beam position, blanking and sync
//   prog_t     one SDRAM programming write
//   rom_req_t  tile row read request
//   pal_wr_t   palette write port
//   sd_state_e SDRAM front-end states
//   Default frame sizes
package game_pkg;

    // Default frame, in pixels and lines
    localparam int DEF_H_TOTAL  = 48;
    localparam int DEF_H_ACTIVE = 32;
    localparam int DEF_V_TOTAL  = 24;
    localparam int DEF_V_ACTIVE = 16;

    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       hb;
        logic       vb;
        logic       hs;
        logic       vs;
    } vid_t;

    typedef struct packed {
        logic [21:0] addr;
        logic [15:0] data;
        logic [ 1:0] mask;
    } prog_t;

    // Address counts 32-bit words
    typedef struct packed {
        logic [12:0] addr;
        logic        cs;
    } rom_req_t;

    typedef struct packed {
        logic        we;
        logic [ 3:0] idx;
        logic [14:0] rgb;   // 5/5/5, red on top
    } pal_wr_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RD_LO = 2'd1,
        RD_HI = 2'd2
    } sd_state_e;

endpackage

// File: rtl/game_cen.sv
// Pixel clock enables
//   pxl2_cen one clk in 4
//   pxl_cen  one clk in 8, together with pxl2_cen
`timescale 1ns/1ns

module game_cen (
    input  logic rst,
    input  logic clk,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [2:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= 3'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 3'd1;
            // Decoded one count early so both land on the same clk
            pxl2_cen <= cnt[1:0] == 2'd2;
            pxl_cen  <= cnt == 3'd6;
        end
    end

endmodule

// File: rtl/game_vtimer.sv
// Video timing
//   Horizontal and vertical beam counters
//   Blanking and sync flags, registered with the counters
`timescale 1ns/1ns

module game_vtimer import game_pkg::*; #(
    parameter int H_TOTAL  = DEF_H_TOTAL,
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int V_TOTAL  = DEF_V_TOTAL,
    parameter int V_ACTIVE = DEF_V_ACTIVE
) (
    input  logic rst,
    input  logic clk,
    input  logic pxl_cen,
    output vid_t vid
);

    logic [8:0] next_h;
    logic [8:0] next_v;

    // Counter values after the coming pxl_cen
    always_comb begin
        next_h = vid.hdump + 9'd1;
        next_v = vid.vdump;
        if (vid.hdump == 9'(H_TOTAL - 1)) begin
            next_h = 9'd0;
            if (vid.vdump == 9'(V_TOTAL - 1)) begin
                next_v = 9'd0;
            end else begin
                next_v = vid.vdump + 9'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vid <= '0;
        end else if (pxl_cen) begin
            vid.hdump <= next_h;
            vid.vdump <= next_v;
            vid.hb    <= next_h >= 9'(H_ACTIVE);
            vid.vb    <= next_v >= 9'(V_ACTIVE);
            // Four pixel wide pulse inside the blanking
            vid.hs    <= next_h >= 9'(H_ACTIVE + 4) && next_h < 9'(H_ACTIVE + 8);
            vid.vs    <= next_v == 9'(V_ACTIVE + 2);
        end
    end

endmodule

// File: rtl/game_char.sv
// Character tile layer
//   Row request one tile ahead of the beam, held until char_ok
//   Row buffer for the returned data
//   Pixel shifter, one 4-bit index per pixel
`timescale 1ns/1ns

module game_char import game_pkg::*; (
    input  logic        rst,
    input  logic        clk,
    input  logic        pxl_cen,
    input  vid_t        vid,
    input  logic        char_ok,
    input  logic [31:0] char_data,
    output rom_req_t    char_req,
    output logic [ 3:0] pxl
);

    logic [31:0] row_buf;
    logic        row_ok;
    logic [31:0] pxl_sr;
    logic [ 4:0] col_nxt;
    logic        tile_start;

    assign tile_start = vid.hdump[2:0] == 3'd0;
    assign col_nxt    = vid.hdump[7:3] + 5'd1;
    assign pxl        = pxl_sr[3:0];

    always_ff @(posedge clk) begin
        if (char_ok) begin
            row_buf <= char_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            char_req <= '0;
            row_ok   <= 1'b0;
            pxl_sr   <= 32'd0;
        end else begin
            if (char_ok) begin
                char_req.cs <= 1'b0;
                row_ok      <= 1'b1;
            end
            if (pxl_cen) begin
                if (tile_start) begin
                    // A late row leaves the tile at index 0
                    pxl_sr        <= row_ok ? row_buf : 32'd0;
                    row_ok        <= 1'b0;
                    char_req.cs   <= 1'b1;
                    char_req.addr <= {vid.vdump[7:3], col_nxt, vid.vdump[2:0]};
                end else begin
                    // Pixel n sits in nibble n
                    pxl_sr <= pxl_sr >> 4;
                end
            end
        end
    end

endmodule

// File: rtl/game_sdram.sv
// SDRAM front end
//   Download byte pairs packed into 16-bit programming writes
//   Tile row reads split into two 16-bit bank reads
`timescale 1ns/1ns

module game_sdram import game_pkg::*; (
    input  logic        rst,
    input  logic        clk,
    input  rom_req_t    char_req,
    output logic        char_ok,
    output logic [31:0] char_data,
    input  logic        downloading,
    output logic        dwnld_busy,
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    output prog_t       prog,
    output logic        prog_we,
    output logic [21:0] ba_addr,
    output logic        ba_rd,
    input  logic        ba_ack,
    input  logic        ba_dok,
    input  logic [15:0] data_read
);

    sd_state_e   state;
    logic [12:0] rd_addr;
    logic [15:0] lo_word;
    logic [ 7:0] even_byte;

    assign dwnld_busy = downloading;

    // Download packing
    always_ff @(posedge clk) begin
        if (ioctl_wr && !ioctl_addr[0]) begin
            even_byte <= ioctl_data;
        end
        if (ioctl_wr && ioctl_addr[0]) begin
            prog.addr <= ioctl_addr[22:1];
            prog.data <= {ioctl_data, even_byte};
            prog.mask <= 2'b00;
        end
        if (ba_dok && state == RD_LO) begin
            lo_word <= data_read;
        end
        if (ba_dok && state == RD_HI) begin
            char_data <= {data_read, lo_word};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
            state   <= IDLE;
            ba_rd   <= 1'b0;
            ba_addr <= 22'd0;
            rd_addr <= 13'd0;
            char_ok <= 1'b0;
        end else begin
            prog_we <= ioctl_wr && ioctl_addr[0];
            char_ok <= 1'b0;
            case (state)
                IDLE: if (char_req.cs && !char_ok && !downloading) begin
                    rd_addr <= char_req.addr;
                    ba_addr <= {8'd0, char_req.addr, 1'b0};
                    ba_rd   <= 1'b1;
                    state   <= RD_LO;
                end
                RD_LO: begin
                    if (ba_ack) ba_rd <= 1'b0;
                    if (ba_dok) begin
                        ba_addr <= {8'd0, rd_addr, 1'b1};
                        ba_rd   <= 1'b1;
                        state   <= RD_HI;
                    end
                end
                RD_HI: begin
                    if (ba_ack) ba_rd <= 1'b0;
                    if (ba_dok) begin
                        // A request that moved on meanwhile is read again
                        char_ok <= char_req.cs && char_req.addr == rd_addr;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: rtl/game_colmix.sv
// Colour stage
//   16-entry palette RAM with its write port
//   Colour lookup and blanking
//   RGB, delayed blanking and sync registered together
`timescale 1ns/1ns

module game_colmix import game_pkg::*; (
    input  logic       rst,
    input  logic       clk,
    input  logic       pxl_cen,
    input  vid_t       vid,
    input  logic [3:0] pxl,
    input  pal_wr_t    pal_wr,
    output logic [4:0] red,
    output logic [4:0] green,
    output logic [4:0] blue,
    output logic       LHBL_dly,
    output logic       LVBL_dly,
    output logic       HS,
    output logic       VS
);

    logic [14:0] pal_ram [0:15];
    logic [14:0] col;

    assign {red, green, blue} = col;

    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_ram[pal_wr.idx] <= pal_wr.rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            col      <= 15'd0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            HS       <= 1'b0;
            VS       <= 1'b0;
        end else if (pxl_cen) begin
            // Black outside the active area
            col      <= (vid.hb || vid.vb) ? 15'd0 : pal_ram[pxl];
            LHBL_dly <= ~vid.hb;
            LVBL_dly <= ~vid.vb;
            HS       <= vid.hs;
            VS       <= vid.vs;
        end
    end

endmodule

// File: rtl/game.sv
// Game top level
//   Clock enables, video timing, character layer,
//   colour stage and SDRAM front end
`timescale 1ns/1ns

module game import game_pkg::*; #(
    parameter int H_TOTAL  = DEF_H_TOTAL,
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int V_TOTAL  = DEF_V_TOTAL,
    parameter int V_ACTIVE = DEF_V_ACTIVE
) (
    input  logic        rst,
    input  logic        clk,
    output logic        pxl2_cen,
    output logic        pxl_cen,
    output logic [ 4:0] red,
    output logic [ 4:0] green,
    output logic [ 4:0] blue,
    output logic        LHBL_dly,
    output logic        LVBL_dly,
    output logic        HS,
    output logic        VS,
    // ROM download
    input  logic        downloading,
    output logic        dwnld_busy,
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    output prog_t       prog,
    output logic        prog_we,
    // SDRAM bank
    output logic [21:0] ba_addr,
    output logic        ba_rd,
    input  logic        ba_ack,
    input  logic        ba_dok,
    input  logic [15:0] data_read,
    // Palette port
    input  pal_wr_t     pal_wr
);

    vid_t        vid;
    rom_req_t    char_req;
    logic        char_ok;
    logic [31:0] char_data;
    logic [ 3:0] pxl;

    game_cen u_cen (
        .rst      ( rst      ),
        .clk      ( clk      ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    game_vtimer #(
        .H_TOTAL  ( H_TOTAL  ),
        .H_ACTIVE ( H_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE )
    ) u_vtimer (
        .rst      ( rst      ),
        .clk      ( clk      ),
        .pxl_cen  ( pxl_cen  ),
        .vid      ( vid      )
    );

    game_char u_char (
        .rst       ( rst       ),
        .clk       ( clk       ),
        .pxl_cen   ( pxl_cen   ),
        .vid       ( vid       ),
        .char_ok   ( char_ok   ),
        .char_data ( char_data ),
        .char_req  ( char_req  ),
        .pxl       ( pxl       )
    );

    game_sdram u_sdram (
        .rst         ( rst         ),
        .clk         ( clk         ),
        .char_req    ( char_req    ),
        .char_ok     ( char_ok     ),
        .char_data   ( char_data   ),
        .downloading ( downloading ),
        .dwnld_busy  ( dwnld_busy  ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog        ( prog        ),
        .prog_we     ( prog_we     ),
        .ba_addr     ( ba_addr     ),
        .ba_rd       ( ba_rd       ),
        .ba_ack      ( ba_ack      ),
        .ba_dok      ( ba_dok      ),
        .data_read   ( data_read   )
    );

    game_colmix u_colmix (
        .rst      ( rst      ),
        .clk      ( clk      ),
        .pxl_cen  ( pxl_cen  ),
        .vid      ( vid      ),
        .pxl      ( pxl      ),
        .pal_wr   ( pal_wr   ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly ),
        .HS       ( HS       ),
        .VS       ( VS       )
    );

endmodule

// File: dv/game_tb.sv
// Testbench of the game top level
//   Clock, reset and SDRAM bank model
//   Trace reader for downloads, palette writes and sampled frames
//   Reference beam and tile model with per-pixel checks
`timescale 1ns/1ns

module game_tb import game_pkg::*; ();

    localparam int HT = DEF_H_TOTAL;
    localparam int HA = DEF_H_ACTIVE;
    localparam int VT = DEF_V_TOTAL;
    localparam int VA = DEF_V_ACTIVE;

    logic        clk, rst, downloading, ioctl_wr, ba_ack, ba_dok;
    logic [24:0] ioctl_addr;
    logic [ 7:0] ioctl_data;
    logic [15:0] data_read;
    pal_wr_t     pal_wr;
    logic        pxl2_cen, pxl_cen, LHBL_dly, LVBL_dly, HS, VS;
    logic [ 4:0] red, green, blue;
    logic        dwnld_busy, prog_we, ba_rd;
    prog_t       prog;
    logic [21:0] ba_addr;

    int          val_errors = 0;
    int          other_errors = 0;
    int          prog_seen = 0;
    int          prog_exp = 0;
    logic [14:0] pal_ref [0:15];
    int          samp_frame = -1;
    int          cur_frame = 0;
    int          chk_v = 0;
    int          vis_cnt = 0;
    bit          aborted = 1'b0;

    game #(.H_TOTAL(HT), .H_ACTIVE(HA), .V_TOTAL(VT), .V_ACTIVE(VA)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic finish_run();
        $display("Errors: %0d value mismatches, %0d other failures", val_errors, other_errors);
        if (val_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            val_errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic report_fail(input string msg);
        other_errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic timeout_fail(input string msg);
        report_fail({"timeout while waiting for ", msg});
        aborted = 1'b1;
    endtask

    // Tile row as the bank model returns it
    function automatic logic [31:0] row_of(input logic [12:0] a);
        logic [15:0] lo;
        logic [15:0] hi;
        lo = {2'b00, a, 1'b0} ^ 16'hA5C3;
        hi = {2'b00, a, 1'b1} ^ 16'hA5C3;
        return {hi, lo};
    endfunction

    // SDRAM bank with random ack and dok delays
    initial begin
        int          d;
        logic [21:0] a;
        void'($urandom(32'h3636b5e7));
        @(negedge clk);
        forever begin
            if (ba_rd) begin
                a = ba_addr;
                // Tile reads stay inside the low 16k words
                check_val("ba_addr[21:14]", a[21:14], 8'd0);
                d = $urandom_range(4, 1);
                repeat (d - 1) @(negedge clk);
                ba_ack = 1'b1;
                @(negedge clk);
                ba_ack = 1'b0;
                d = $urandom_range(3, 1);
                repeat (d - 1) @(negedge clk);
                data_read = a[15:0] ^ 16'hA5C3;
                ba_dok = 1'b1;
                @(negedge clk);
                ba_dok = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    end

    // Enable periods and download side rules
    initial begin
        int cen_gap;
        int cen2_gap;
        bit seen;
        bit seen2;
        forever begin
            @(negedge clk);
            if (rst) begin
                seen  = 0;
                seen2 = 0;
            end else begin
                if (pxl_cen) begin
                    if (seen) assert (cen_gap == 8) else report_fail("pxl_cen period not 8");
                    assert (pxl2_cen) else report_fail("pxl_cen without pxl2_cen");
                    seen    = 1;
                    cen_gap = 1;
                end else begin
                    cen_gap++;
                end
                if (pxl2_cen) begin
                    if (seen2) assert (cen2_gap == 4) else report_fail("pxl2_cen period not 4");
                    seen2    = 1;
                    cen2_gap = 1;
                end else begin
                    cen2_gap++;
                end
                check_val("dwnld_busy", dwnld_busy, downloading);
                if (downloading) check_val("ba_rd", ba_rd, 1'b0);
                if (prog_we) prog_seen++;
            end
        end
    end

    // Reference beam, tile fetch and colour model
    initial begin
        int          mh, mv, mf, e_h, e_v, e_f;
        int          line_pix, line_vis, fr_lines, fr_vis;
        logic [31:0] msr;
        logic [12:0] req_addr;
        logic [ 4:0] col;
        logic [ 3:0] e_nib;
        bit          req_valid, pend, e_hb, e_vb;
        bit          hs_q, vs_q, line_go, frame_go;
        forever begin
            @(negedge clk);
            if (rst) begin
                mh = 0;
                mv = 0;
                mf = 0;
                msr = 0;
                req_valid = 0;
                pend = 0;
                hs_q = 0;
                vs_q = 0;
                line_go = 0;
                frame_go = 0;
            end else begin
                if (pend) begin
                    check_val("LHBL_dly", LHBL_dly, !e_hb);
                    check_val("LVBL_dly", LVBL_dly, !e_vb);
                    check_val("HS", HS, e_h >= HA + 4 && e_h < HA + 8);
                    check_val("VS", VS, e_v == VA + 2);
                    if (e_hb || e_vb) begin
                        check_val("rgb", {red, green, blue}, 15'd0);
                    end else if (e_f == samp_frame) begin
                        check_val("rgb", {red, green, blue}, pal_ref[e_nib]);
                        vis_cnt++;
                    end
                    // Line and frame lengths measured between sync edges
                    if (VS && !vs_q) begin
                        if (frame_go) begin
                            assert (fr_lines == VT && fr_vis == VA)
                                else report_fail("wrong line counts in frame");
                        end
                        fr_lines = 0;
                        fr_vis = 0;
                        frame_go = 1;
                    end
                    if (HS && !hs_q) begin
                        if (line_go) begin
                            assert (line_pix == HT && line_vis == HA)
                                else report_fail("wrong pixel counts in line");
                        end
                        line_pix = 0;
                        line_vis = 0;
                        line_go = 1;
                        fr_lines++;
                        if (LVBL_dly) fr_vis++;
                    end
                    line_pix++;
                    if (LHBL_dly) line_vis++;
                    hs_q = HS;
                    vs_q = VS;
                    cur_frame = e_f;
                    chk_v = e_v;
                    pend = 0;
                end
                if (pxl_cen) begin
                    e_h = mh;
                    e_v = mv;
                    e_f = mf;
                    e_hb = mh >= HA;
                    e_vb = mv >= VA;
                    e_nib = msr[3:0];
                    if (mh % 8 == 0) begin
                        msr = req_valid ? row_of(req_addr) : 32'd0;
                        col = 5'(mh / 8) + 5'd1;
                        req_addr = {5'(mv / 8), col, 3'(mv % 8)};
                        req_valid = 1;
                    end else begin
                        msr = msr >> 4;
                    end
                    mh++;
                    if (mh == HT) begin
                        mh = 0;
                        mv++;
                        if (mv == VT) begin
                            mv = 0;
                            mf++;
                        end
                    end
                    pend = 1;
                end
            end
        end
    end

    task automatic send_byte(input logic [24:0] a, input logic [7:0] b, input logic [15:0] w);
        int n;
        @(negedge clk);
        ioctl_addr = a;
        ioctl_data = b;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        if (a[0]) begin
            n = 0;
            while (!prog_we && n < 4) begin
                @(negedge clk);
                n++;
            end
            if (!prog_we) begin
                timeout_fail("prog_we");
            end else begin
                check_val("prog.addr", prog.addr, a[22:1]);
                check_val("prog.data", prog.data, w);
                check_val("prog.mask", prog.mask, 2'b00);
                prog_exp++;
            end
        end
    endtask

    task automatic write_pal(input logic [3:0] idx, input logic [14:0] rgb);
        @(negedge clk);
        pal_wr = '{we: 1'b1, idx: idx, rgb: rgb};
        @(negedge clk);
        pal_wr.we = 1'b0;
        pal_ref[idx] = rgb;
    endtask

    task automatic sample_frame(input int f);
        int n;
        int limit;
        assert (f > cur_frame) else report_fail("sampled frame has already started");
        samp_frame = f;
        vis_cnt = 0;
        limit = (f - cur_frame + 2) * HT * VT * 8;
        n = 0;
        while (!(cur_frame > f || (cur_frame == f && chk_v >= VA)) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (n >= limit) begin
            timeout_fail("end of sampled frame");
        end else begin
            samp_frame = -1;
            assert (vis_cnt == HA * VA) else report_fail("not every visible pixel was sampled");
        end
    endtask

    initial begin
        int          fd, n, f;
        string       tok, line;
        logic [24:0] a;
        logic [15:0] b, w;
        rst = 1'b1;
        downloading = 1'b1;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        ba_ack = 1'b0;
        ba_dok = 1'b0;
        data_read = '0;
        pal_wr = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        fd = $fopen("dv/game_trace.txt", "r");
        if (fd == 0) begin
            report_fail("cannot open the trace file");
        end else begin
            while (!$feof(fd) && !aborted) begin
                n = $fscanf(fd, "%s", tok);
                if (n != 1) break;
                if (tok == "#") begin
                    void'($fgets(line, fd));
                end else if (tok == "D") begin
                    w = '0;
                    n = $fscanf(fd, "%h %h", a, b);
                    if (a[0]) n = $fscanf(fd, "%h", w);
                    send_byte(a, b[7:0], w);
                end else begin
                    if (downloading) begin
                        @(negedge clk);
                        downloading = 1'b0;
                    end
                    if (tok == "P") begin
                        n = $fscanf(fd, "%h %h", a, b);
                        write_pal(a[3:0], b[14:0]);
                    end else if (tok == "S") begin
                        n = $fscanf(fd, "%d", f);
                        sample_frame(f);
                    end else begin
                        report_fail({"unknown trace record ", tok});
                    end
                end
            end
            $fclose(fd);
        end
        if (!aborted) begin
            repeat (20) @(negedge clk);
            assert (prog_seen == prog_exp) else report_fail("prog_we pulse count differs");
        end
        finish_run();
    end

endmodule

// File: compile.f
rtl/game_pkg.sv
rtl/game_cen.sv
rtl/game_vtimer.sv
rtl/game_char.sv
rtl/game_sdram.sv
rtl/game_colmix.sv
rtl/game.sv
dv/game_tb.sv

// File: dv/game_trace.txt
# Records: D addr byte [prog word on odd addr] | P idx rgb | S frame
# D and P fields in hex, S frame number in decimal, counted from reset
D 000100 34
D 000101 12 1234
D 000102 cd
D 000103 ab abcd
D 000104 0f
D 000105 f0 f00f
D 002a06 5a
D 002a07 a5 a55a
P 0 0000
P 1 7c00
P 2 03e0
P 3 001f
P 4 7fff
P 5 4210
P 6 2108
P 7 7c1f
P 8 03ff
P 9 7fe0
P a 1234
P b 5678
P c 0f0f
P d 70f0
P e 0c63
P f 318c
S 2
P 5 1357
P a 0421
S 3
